//--- sources.f
+incdir+common
+incdir+sim
common/cpu_pkg.sv
verilog/mem_port.sv
cpu/alu.sv
cpu/register_file.sv
cpu/instr_decoder.sv
cpu/program_counter.sv
cpu/cpu_sequencer.sv
cpu/five_cycle_cpu.sv
sim/tb_five_cycle_cpu.sv

//--- sim/tb_tasks.svh
    // instruction encoders, fields in ISA order
    function automatic word_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {funct7, rs2, rs1, funct3, rd, `CPU_OP_REG};
    endfunction

    function automatic word_t i_type(input logic [6:0] op, input logic [2:0] funct3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [31:0] imm);
        return {imm[11:0], rs1, funct3, rd, op};
    endfunction

    function automatic word_t s_type(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `CPU_OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [2:0] funct3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], `CPU_OP_BRANCH};
    endfunction

    function automatic word_t j_type(input reg_idx_t rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `CPU_OP_JAL};
    endfunction

    function automatic word_t u_type(input reg_idx_t rd, input logic [19:0] upper);
        return {upper, rd, `CPU_OP_LUI};
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic flag_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    function automatic int begin_test();
        program_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        return error_count;
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s (%s): pass", name, mode_name);
        end else begin
            fail_count++;
            $display("%s (%s): fail, %0d errors", name, mode_name, error_count - errors_before);
        end
    endtask

    task automatic expect_store(input addr_t addr, input word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'hf00d_0000 ^ word_t'(i * 4);
        program_q.push_back(s_type(0, 0, MARKER_ADDR)); // end marker
        program_q.push_back(j_type(0, 0));               // park on a jump to itself
        for (int i = 0; i < program_q.size(); i++)
            mem[(`CPU_RESET_PC >> 2) + i] = program_q[i];
    endtask

    task automatic run_program(input int len);
        int cycles;
        @(posedge clk);
        #1;
        rst = 1'b0;
        load_program();
        repeat (5) begin
            @(posedge clk);
            #1;
            check_word("mem_req", word_t'(mem_req), '0);
        end
        fetch_q.delete();
        store_addr_q.delete();
        store_data_q.delete();
        req_count   = 0;
        marker_seen = 1'b0;
        rst         = 1'b1;
        cycles      = 0;
        while (!marker_seen && cycles < len * MAX_CPI + TEST_SLACK) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!marker_seen)
            flag_error($sformatf("program did not reach its end marker in %0d cycles", cycles));
    endtask

    task automatic stores_match();
        if (store_addr_q.size() != exp_addr_q.size())
            flag_error($sformatf("saw %0d stores where %0d were expected",
                                 store_addr_q.size(), exp_addr_q.size()));
        for (int i = 0; i < store_addr_q.size() && i < exp_addr_q.size(); i++) begin
            check_addr($sformatf("mem_cmd.addr of store %0d", i), store_addr_q[i], exp_addr_q[i]);
            check_word($sformatf("mem_cmd.wdata of store %0d", i), store_data_q[i],
                       exp_data_q[i]);
        end
    endtask

    task automatic reset_fetch_test();
        int errors_before;
        errors_before = begin_test();
        run_program(LEN_RESET);
        if (req_count == 0)
            flag_error("no bus request was seen after reset");
        check_addr("first mem_cmd.addr", first_cmd.addr, `CPU_RESET_PC);
        check_word("first mem_cmd.write", word_t'(first_cmd.write), '0);
        stores_match();
        finish_test("reset_fetch", errors_before);
    endtask

    task automatic alu_ops_test();
        word_t a;
        word_t b;
        word_t c;
        int    errors_before;
        errors_before = begin_test();
        a = 32'd1234;
        b = 32'hffff_fff9; // -7
        c = {20'habcde, 12'h000};
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 1, 0, 1234));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 2, 0, -7));
        program_q.push_back(u_type(3, 20'habcde));
        program_q.push_back(r_type(7'h00, 3'b000, 4, 1, 2));  // add
        program_q.push_back(r_type(7'h20, 3'b000, 5, 1, 2));  // sub
        program_q.push_back(r_type(7'h00, 3'b111, 6, 3, 2));  // and
        program_q.push_back(r_type(7'h00, 3'b110, 7, 1, 3));  // or
        program_q.push_back(r_type(7'h00, 3'b100, 8, 2, 3));  // xor
        program_q.push_back(r_type(7'h00, 3'b010, 9, 2, 1));  // slt
        program_q.push_back(r_type(7'h00, 3'b010, 10, 1, 2));
        program_q.push_back(r_type(7'h00, 3'b010, 11, 3, 2)); // both negative
        for (int k = 1; k <= 11; k++)
            program_q.push_back(s_type(reg_idx_t'(k), 0, DATA_BASE + 4 * (k - 1)));
        expect_store(DATA_BASE + 0, a);
        expect_store(DATA_BASE + 4, b);
        expect_store(DATA_BASE + 8, c);
        expect_store(DATA_BASE + 12, a + b);
        expect_store(DATA_BASE + 16, a - b);
        expect_store(DATA_BASE + 20, c & b);
        expect_store(DATA_BASE + 24, a | c);
        expect_store(DATA_BASE + 28, b ^ c);
        expect_store(DATA_BASE + 32, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expect_store(DATA_BASE + 36, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expect_store(DATA_BASE + 40, ($signed(c) < $signed(b)) ? 32'd1 : 32'd0);
        run_program(LEN_ALU);
        stores_match();
        finish_test("alu_ops", errors_before);
    endtask

    task automatic load_store_test();
        word_t pattern;
        int    errors_before;
        errors_before = begin_test();
        pattern = {20'h12345, 12'h000} + 32'h678;
        program_q.push_back(u_type(1, 20'h12345));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 1, 1, 32'h678));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 3, 0, 32'h480)); // base register
        program_q.push_back(s_type(1, 3, 32'h80));
        program_q.push_back(i_type(`CPU_OP_LOAD, 3'b010, 2, 3, 32'h80));
        program_q.push_back(s_type(2, 0, DATA_BASE));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 0, 0, 55));      // x0 ignores it
        program_q.push_back(s_type(0, 0, DATA_BASE + 4));
        program_q.push_back(i_type(`CPU_OP_LOAD, 3'b010, 0, 3, 32'h80));
        program_q.push_back(s_type(0, 0, DATA_BASE + 8));
        expect_store(32'h480 + 32'h80, pattern);
        expect_store(DATA_BASE, pattern);
        expect_store(DATA_BASE + 4, '0);
        expect_store(DATA_BASE + 8, '0);
        run_program(LEN_MEM);
        stores_match();
        finish_test("load_store", errors_before);
    endtask

    task automatic branch_jal_test();
        addr_t path [LEN_BRANCH] = '{32'h00, 32'h04, 32'h08, 32'h08 + 12, 32'h18, 32'h1c,
                                     32'h1c + 12, 32'h2c, 32'h2c + 12, 32'h3c, 32'h40,
                                     32'h40 - 4, 32'h40, 32'h44, 32'h48, 32'h4c};
        int    errors_before;
        errors_before = begin_test();
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 1, 0, 5));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 2, 0, 5));
        program_q.push_back(b_type(3'b000, 1, 2, 12));            // beq taken
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 5, 0, 1));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 5, 0, 2));
        program_q.push_back(b_type(3'b001, 1, 2, 8));             // bne falls through
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 3, 0, 9));
        program_q.push_back(b_type(3'b001, 1, 3, 12));            // bne taken
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 5, 0, 3));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 5, 0, 4));
        program_q.push_back(b_type(3'b000, 1, 3, 8));             // beq falls through
        program_q.push_back(j_type(6, 12));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 5, 0, 5));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 5, 0, 6));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 7, 0, 2));
        program_q.push_back(i_type(`CPU_OP_IMM, 3'b000, 7, 7, -1));
        program_q.push_back(b_type(3'b001, 7, 0, -4));            // backward, taken once
        program_q.push_back(s_type(6, 0, DATA_BASE));
        program_q.push_back(s_type(5, 0, DATA_BASE + 4));
        expect_store(DATA_BASE, 32'h2c + 4);                        // link of the jal
        expect_store(DATA_BASE + 4, '0);                            // no skipped addi ran
        run_program(LEN_BRANCH);
        if (fetch_q.size() < LEN_BRANCH)
            flag_error($sformatf("only %0d of %0d fetches seen", fetch_q.size(), LEN_BRANCH));
        for (int i = 0; i < LEN_BRANCH && i < fetch_q.size(); i++)
            check_addr($sformatf("mem_cmd.addr of fetch %0d", i), fetch_q[i], path[i]);
        stores_match();
        finish_test("branch_jal", errors_before);
    endtask

//--- sim/tb_five_cycle_cpu.sv
`timescale 1ns/1ps

`include "cpu_settings.svh"

module tb_five_cycle_cpu;
    import cpu_pkg::*;

    localparam int     CLK_PERIOD  = 100;
    localparam int     MEM_WORDS   = 1024;
    localparam addr_t  DATA_BASE   = 32'h0000_0400; // below this only instructions live
    localparam addr_t  MARKER_ADDR = 32'h0000_07fc;
    localparam int     MAX_CPI     = 64;  // two 20-cycle handshakes plus the fixed steps
    localparam int     TEST_SLACK  = 100;
    localparam int     LEN_RESET   = 1;
    localparam int     LEN_ALU     = 23;
    localparam int     LEN_MEM     = 11;
    localparam int     LEN_BRANCH  = 16;
    localparam int     TOTAL_INSTR = LEN_RESET + 3 * (LEN_ALU + LEN_MEM + LEN_BRANCH);
    localparam int     NUM_TESTS   = 10;
    localparam longint WATCHDOG_NS =
        longint'(TOTAL_INSTR * MAX_CPI + NUM_TESTS * (TEST_SLACK + 20)) * CLK_PERIOD;

    logic     clk;
    logic     rst;
    logic     mem_req;
    mem_cmd_t mem_cmd;
    logic     mem_ack;
    word_t    mem_rdata;

    word_t    mem [MEM_WORDS];
    word_t    program_q[$];
    addr_t    fetch_q[$];
    addr_t    store_addr_q[$];
    word_t    store_data_q[$];
    addr_t    exp_addr_q[$];
    word_t    exp_data_q[$];
    mem_cmd_t first_cmd;
    int       req_count;
    logic     marker_seen;
    mem_cmd_t held_cmd;
    int       ack_wait;
    int       delay_min;
    int       delay_max;
    string    mode_name;
    int       check_count;
    int       error_count;
    int       pass_count;
    int       fail_count;

    five_cycle_cpu dut_i (
        .clk       ( clk ),
        .rst       ( rst ),
        .mem_req   ( mem_req ),
        .mem_cmd   ( mem_cmd ),
        .mem_ack   ( mem_ack ),
        .mem_rdata ( mem_rdata )
    );

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic set_ack_delay(input int lo, input int hi, input string name);
        delay_min = lo;
        delay_max = hi;
        mode_name = name;
    endtask

    task automatic serve_request(input mem_cmd_t cmd);
        if (cmd.addr >= MEM_WORDS * 4 || cmd.addr[1:0] != 2'b00) begin
            flag_error($sformatf("bus access to unmapped or unaligned address %h", cmd.addr));
        end else if (cmd.write) begin
            if (cmd.addr == MARKER_ADDR) begin
                marker_seen = 1'b1;
            end else begin
                mem[cmd.addr[11:2]] = cmd.wdata;
                store_addr_q.push_back(cmd.addr);
                store_data_q.push_back(cmd.wdata);
            end
        end else begin
            mem_rdata = mem[cmd.addr[11:2]];
            if (cmd.addr < DATA_BASE)
                fetch_q.push_back(cmd.addr); // reads in the program area are fetches
        end
    endtask

    // four-phase responder that acks after a random wait and drops ack once req has fallen
    initial begin
        void'($urandom(32'hab6d1cbe));
        forever begin
            @(posedge clk);
            #1;
            if (rst && mem_req) begin
                held_cmd = mem_cmd;
                if (req_count == 0)
                    first_cmd = mem_cmd;
                req_count++;
                ack_wait = delay_min + int'($urandom % (delay_max - delay_min + 1));
                while (ack_wait > 0 && rst) begin
                    @(posedge clk);
                    #1;
                    if (rst) begin
                        check_word("mem_req", word_t'(mem_req), 32'd1);
                        check_addr("mem_cmd.addr", mem_cmd.addr, held_cmd.addr);
                        check_word("mem_cmd.wdata", mem_cmd.wdata, held_cmd.wdata);
                        check_word("mem_cmd.write", word_t'(mem_cmd.write),
                                   word_t'(held_cmd.write));
                    end
                    ack_wait--;
                end
                if (rst) begin
                    serve_request(held_cmd);
                    mem_ack = 1'b1;
                    @(posedge clk);
                    #1;
                    while (mem_req && rst) begin
                        @(posedge clk);
                        #1;
                    end
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not end within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b0;
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        req_count   = 0;
        marker_seen = 1'b0;
        check_count = 0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;

        set_ack_delay(1, 6, "ack 1-6");
        reset_fetch_test();
        alu_ops_test();
        load_store_test();
        branch_jal_test();

        set_ack_delay(10, 20, "ack 10-20");
        alu_ops_test();
        load_store_test();
        branch_jal_test();

        set_ack_delay(0, 0, "ack 0");
        alu_ops_test();
        load_store_test();
        branch_jal_test();

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 pass_count, fail_count, check_count, error_count);
        if (fail_count == 0 && error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- cpu/five_cycle_cpu.sv
`timescale 1ns/1ps

module five_cycle_cpu (
    input  logic             clk,
    input  logic             rst,
    output logic             mem_req,
    output cpu_pkg::mem_cmd_t mem_cmd,
    input  logic             mem_ack,
    input  cpu_pkg::word_t   mem_rdata
);
    import cpu_pkg::*;

    addr_t    pc;
    addr_t    target;
    logic     pc_advance;
    logic     pc_jump;

    word_t    instr;
    decoded_t dec;

    word_t    rs1_data;
    word_t    rs2_data;
    logic     rd_write;
    word_t    rd_data;

    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     taken;

    logic     port_start;
    mem_cmd_t port_cmd;
    logic     port_done;
    word_t    port_rdata;

    cpu_sequencer sequencer_i (
        .clk        ( clk ),
        .rst        ( rst ),
        .pc         ( pc ),
        .dec        ( dec ),
        .rs1_data   ( rs1_data ),
        .rs2_data   ( rs2_data ),
        .alu_result ( alu_result ),
        .taken      ( taken ),
        .mem_start  ( port_start ),
        .mem_cmd    ( port_cmd ),
        .mem_done   ( port_done ),
        .mem_data   ( port_rdata ),
        .instr      ( instr ),
        .alu_a      ( alu_a ),
        .alu_b      ( alu_b ),
        .rd_write   ( rd_write ),
        .rd_data    ( rd_data ),
        .pc_advance ( pc_advance ),
        .pc_jump    ( pc_jump )
    );

    program_counter pc_i (
        .clk     ( clk ),
        .rst     ( rst ),
        .advance ( pc_advance ),
        .jump    ( pc_jump ),
        .target  ( target ),
        .pc      ( pc )
    );

    instr_decoder decoder_i (
        .instr ( instr ),
        .dec   ( dec )
    );

    alu alu_i (
        .op        ( dec.alu_op ),
        .a         ( alu_a ),
        .b         ( alu_b ),
        .pc        ( pc ),
        .imm       ( dec.imm ),
        .branch_ne ( dec.branch_ne ),
        .result    ( alu_result ),
        .taken     ( taken ),
        .target    ( target )
    );

    register_file regs_i (
        .clk      ( clk ),
        .rst      ( rst ),
        .rs1      ( dec.rs1 ),
        .rs2      ( dec.rs2 ),
        .rs1_data ( rs1_data ),
        .rs2_data ( rs2_data ),
        .rd       ( dec.rd ),   // instr register holds still until writeback
        .rd_write ( rd_write ),
        .rd_data  ( rd_data )
    );

    mem_port mem_port_i (
        .clk       ( clk ),
        .rst       ( rst ),
        .start     ( port_start ),
        .cmd_in    ( port_cmd ),
        .done      ( port_done ),
        .rdata_out ( port_rdata ),
        .mem_req   ( mem_req ),
        .mem_cmd   ( mem_cmd ),
        .mem_ack   ( mem_ack ),
        .mem_rdata ( mem_rdata )
    );

endmodule

//--- cpu/cpu_sequencer.sv
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpu_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::addr_t    pc,
    input  cpu_pkg::decoded_t dec,
    input  cpu_pkg::word_t    rs1_data,
    input  cpu_pkg::word_t    rs2_data,
    input  cpu_pkg::word_t    alu_result,
    input  logic              taken,
    output logic              mem_start,
    output cpu_pkg::mem_cmd_t mem_cmd,
    input  logic              mem_done,
    input  cpu_pkg::word_t    mem_data,
    output cpu_pkg::word_t    instr,
    output cpu_pkg::word_t    alu_a,
    output cpu_pkg::word_t    alu_b,
    output logic              rd_write,
    output cpu_pkg::word_t    rd_data,
    output logic              pc_advance,
    output logic              pc_jump
);
    import cpu_pkg::*;

    step_e    step;
    logic     issued;      // request handed to mem_port and not yet done
    word_t    instr_q;
    decoded_t dec_q;
    word_t    rs1_q;
    word_t    rs2_q;
    word_t    result_q;
    logic     taken_q;
    word_t    load_q;
    logic     mem_access;

    assign mem_access = dec_q.is_load || dec_q.is_store;

    always_ff @(posedge clk) begin
        if (!rst) begin
            step   <= step_fetch;
            issued <= 1'b0;
        end else begin
            if (mem_start)
                issued <= 1'b1;
            else if (mem_done)
                issued <= 1'b0;
            case (step)
                step_fetch:     if (mem_done) step <= step_decode;
                step_decode:    step <= step_execute;
                step_execute:   step <= step_memory;
                step_memory:    if (!mem_access || mem_done) step <= step_writeback;
                step_writeback: step <= step_fetch;
                default:        step <= step_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (step == step_fetch && mem_done)
            instr_q <= mem_data;
        if (step == step_decode) begin
            dec_q <= dec;
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
        end
        if (step == step_execute) begin
            result_q <= alu_result;
            taken_q  <= taken;
        end
        if (step == step_memory && mem_done)
            load_q <= mem_data;
    end

    assign instr = instr_q;
    assign alu_a = rs1_q;
    assign alu_b = dec_q.use_imm ? dec_q.imm : rs2_q;

    assign mem_start = !issued && (step == step_fetch || (step == step_memory && mem_access));

    always_comb begin
        if (step == step_fetch)
            mem_cmd = '{addr: pc, wdata: '0, write: 1'b0};
        else
            mem_cmd = '{addr: result_q, wdata: rs2_q, write: dec_q.is_store};
    end

    always_comb begin
        if (dec_q.is_load)
            rd_data = load_q;
        else if (dec_q.is_jal)
            rd_data = pc + `CPU_PC_STEP; // link address
        else
            rd_data = result_q;
    end

    assign rd_write   = step == step_writeback && dec_q.writes_rd;
    assign pc_jump    = step == step_writeback && (dec_q.is_jal || (dec_q.is_branch && taken_q));
    assign pc_advance = step == step_writeback && !pc_jump;

    // mem_port answers only a request issued from the fetch or memory step
    assert property (@(posedge clk) disable iff (!rst)
        mem_done |-> issued && (step == step_fetch || step == step_memory));

endmodule

//--- cpu/program_counter.sv
`timescale 1ns/1ps

`include "cpu_settings.svh"

module program_counter (
    input  logic           clk,
    input  logic           rst,
    input  logic           advance,
    input  logic           jump,
    input  cpu_pkg::addr_t target,
    output cpu_pkg::addr_t pc
);
    import cpu_pkg::*;

    addr_t pc_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc_q <= `CPU_RESET_PC;
        end else if (jump) begin
            pc_q <= target;
        end else if (advance) begin
            pc_q <= pc_q + `CPU_PC_STEP;
        end
    end

    assign pc = pc_q;

    // the sequencer picks exactly one way to leave writeback
    assert property (@(posedge clk) disable iff (!rst) !(advance && jump));

endmodule

//--- cpu/instr_decoder.sv
`timescale 1ns/1ps

`include "cpu_settings.svh"

module instr_decoder (
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::decoded_t dec
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec        = '0;     // anything not matched below retires as a no-op
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];
        dec.alu_op = alu_add;

        case (opcode)
            `CPU_OP_REG: begin
                dec.writes_rd = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b010:  dec.alu_op = alu_slt;
                    3'b100:  dec.alu_op = alu_xor;
                    3'b110:  dec.alu_op = alu_or;
                    3'b111:  dec.alu_op = alu_and;
                    default: dec.writes_rd = 1'b0; // shifts and sltu not kept
                endcase
            end
            `CPU_OP_IMM: begin
                dec.use_imm   = 1'b1;
                dec.imm       = imm_i;
                dec.writes_rd = funct3 == 3'b000; // addi only
            end
            `CPU_OP_LOAD: begin
                dec.use_imm   = 1'b1;
                dec.imm       = imm_i;
                dec.is_load   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            `CPU_OP_STORE: begin
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            `CPU_OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = funct3 == 3'b000 || funct3 == 3'b001;
                dec.branch_ne = funct3 == 3'b001;
            end
            `CPU_OP_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            `CPU_OP_LUI: begin
                dec.use_imm   = 1'b1;
                dec.imm       = imm_u;
                dec.alu_op    = alu_pass_b;
                dec.writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- cpu/register_file.sv
`timescale 1ns/1ps

`include "cpu_settings.svh"

module register_file (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::word_t   rs1_data,
    output cpu_pkg::word_t   rs2_data,
    input  cpu_pkg::reg_idx_t rd,
    input  logic             rd_write,
    input  cpu_pkg::word_t   rd_data
);
    import cpu_pkg::*;

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (rd_write && rd != '0) begin // x0 stays zero
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- cpu/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::addr_t   pc,
    input  cpu_pkg::word_t   imm,
    input  logic             branch_ne,
    output cpu_pkg::word_t   result,
    output logic             taken,
    output cpu_pkg::addr_t   target
);
    import cpu_pkg::*;

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = word_t'(less);
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    assign taken  = (a == b) ^ branch_ne; // beq, or bne when flipped
    assign target = addr_t'(pc + imm);    // shared by branches and jal

endmodule

//--- verilog/mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  cpu_pkg::mem_cmd_t cmd_in,
    output logic              done,
    output cpu_pkg::word_t    rdata_out,
    output logic              mem_req,
    output cpu_pkg::mem_cmd_t mem_cmd,
    input  logic              mem_ack,
    input  cpu_pkg::word_t    mem_rdata
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        port_idle,
        port_req,    // req high, waiting for ack
        port_done,   // data captured, req dropped
        port_drain   // waiting for ack to fall
    } port_state_e;

    port_state_e state;
    logic        pending;  // start seen while ack was still high
    mem_cmd_t    cmd_q;
    word_t       rdata_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= port_idle;
            pending <= 1'b0;
        end else begin
            case (state)
                port_idle:  if (start) state <= port_req;
                port_req:   if (mem_ack) state <= port_done;
                port_done:  state <= port_drain;
                port_drain: begin
                    if (start)
                        pending <= 1'b1;
                    if (!mem_ack) begin
                        state   <= (pending || start) ? port_req : port_idle;
                        pending <= 1'b0;
                    end
                end
                default:    state <= port_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && (state == port_idle || state == port_drain))
            cmd_q <= cmd_in;
        if (state == port_req && mem_ack)
            rdata_q <= mem_rdata;
    end

    assign mem_req   = state == port_req;
    assign mem_cmd   = cmd_q;
    assign done      = state == port_done;
    assign rdata_out = rdata_q;

    // the memory may sample the command on any cycle before it acks
    assert property (@(posedge clk) disable iff (!rst)
        mem_req && !mem_ack |=> $stable(mem_cmd));

endmodule

//--- common/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_XLEN-1:0] addr_t;
    typedef logic [4:0]           reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b // lui goes through here
    } alu_op_e;

    typedef enum logic [2:0] {
        step_fetch,
        step_decode,
        step_execute,
        step_memory,
        step_writeback
    } step_e;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic     use_imm;   // operand b from imm instead of rs2
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;
        logic     is_jal;
        logic     writes_rd;
        word_t    imm;
    } decoded_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } mem_cmd_t;

endpackage

//--- common/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_XLEN      32
`define CPU_REG_COUNT 32

`define CPU_RESET_PC  32'h0000_0000
`define CPU_PC_STEP   32'd4

// major opcodes, instr[6:0]
`define CPU_OP_REG    7'b0110011
`define CPU_OP_IMM    7'b0010011
`define CPU_OP_LOAD   7'b0000011
`define CPU_OP_STORE  7'b0100011
`define CPU_OP_BRANCH 7'b1100011
`define CPU_OP_JAL    7'b1101111
`define CPU_OP_LUI    7'b0110111

`endif
